/* logic/video_pkg.sv */
`default_nettype none

package video_pkg;

    // 640x480 at 60 Hz, counted in pixel enables
    localparam int h_visible = 640;
    localparam int h_front   = 16;
    localparam int h_sync    = 96;
    localparam int h_total   = 800;

    localparam int h_sync_start = h_visible + h_front;
    localparam int h_sync_end   = h_sync_start + h_sync; // back porch runs to h_total

    localparam int v_visible = 480;
    localparam int v_front   = 10;
    localparam int v_sync    = 2;
    localparam int v_total   = 525;

    localparam int v_sync_start = v_visible + v_front;
    localparam int v_sync_end   = v_sync_start + v_sync;

    // counter width, enough for h_total and v_total
    localparam int coord_w = 10;

    localparam logic [23:0] bg_rgb = 24'h88cc88; // flat green background

    // counter update -> renderer reg -> rom reg -> output reg
    localparam int pipe_depth = 3;

endpackage

`default_nettype wire

/* logic/sprite_pkg.sv */
`default_nettype none

package sprite_pkg;

    localparam int sprite_dim  = 16;
    localparam int sprite_bits = $clog2(sprite_dim); // row and column index width

    localparam int rom_addr_w = 9;
    localparam int texel_w    = 16;

    localparam logic [rom_addr_w-1:0] player_base   = 9'd0;
    localparam logic [rom_addr_w-1:0] obstacle_base = 9'd256;

    // apb address and data width
    localparam int apb_w = 16;

    // player x, player y, obstacle x, obstacle y at pos_base + 0..3
    localparam logic [apb_w-1:0] pos_base = 16'h0100;

    typedef enum logic [1:0] {
        idle,
        setup,
        access,
        commit
    } loader_state_t;

    // texel word: bit 15 opaque, then 5-bit red, green, blue
    // sprite 0 is the player, anything else the obstacle
    function automatic logic [texel_w-1:0] texel_at(input int sprite, input int row,
                                                    input int col);
        logic       opaque;
        logic [4:0] r;
        logic [4:0] g;
        logic [4:0] b;
        opaque = ((row + col) % 4) != 0; // see-through diagonal stripes
        r      = 5'(col * 2);
        g      = 5'(row * 2);
        b      = (sprite == 0) ? 5'd31 : 5'd0;
        return {opaque, r, g, b};
    endfunction

    // 5 to 8 bits, top three bits repeated below
    function automatic logic [7:0] expand_ch(input logic [4:0] c);
        return {c, c[4:2]};
    endfunction

endpackage

`default_nettype wire

/* logic/display_ifs.sv */
`timescale 1ns/1ps
`default_nettype none

// scan position from the timing generator
interface scan_if;
    import video_pkg::*;

    logic               pix_en;
    logic [coord_w-1:0] hcount;
    logic [coord_w-1:0] vcount;
    logic               visible;

    modport source (output pix_en, hcount, vcount, visible);
    modport sink   (input  pix_en, hcount, vcount, visible);
endinterface

// sprite positions, updated once per frame
interface sprite_pos_if;
    import video_pkg::*;

    logic [coord_w-1:0] player_x;
    logic [coord_w-1:0] player_y;
    logic [coord_w-1:0] obstacle_x;
    logic [coord_w-1:0] obstacle_y;

    modport source (output player_x, player_y, obstacle_x, obstacle_y);
    modport sink   (input  player_x, player_y, obstacle_x, obstacle_y);
endinterface

`default_nettype wire

/* logic/vga_timing.sv */
`timescale 1ns/1ps
`default_nettype none

module vga_timing (
    input  logic   sys_clk,
    input  logic   reset,
    scan_if.source scan,
    output logic   hsync,
    output logic   vsync
);
    import video_pkg::*;

    logic               pix_en;
    logic [coord_w-1:0] h_cnt;
    logic [coord_w-1:0] v_cnt;
    logic [coord_w-1:0] h_next;
    logic [coord_w-1:0] v_next;
    logic               line_end;

    assign line_end = (h_cnt == coord_w'(h_total - 1));
    assign h_next   = line_end ? '0 : h_cnt + 1'b1;

    always_comb begin
        v_next = v_cnt;
        if (line_end) begin
            v_next = (v_cnt == coord_w'(v_total - 1)) ? '0 : v_cnt + 1'b1;
        end
    end

    always_ff @(posedge sys_clk or negedge reset) begin
        if (!reset) begin
            pix_en <= 1'b0;
            h_cnt  <= '0;
            v_cnt  <= '0;
            hsync  <= 1'b1; // syncs are active low
            vsync  <= 1'b1;
        end else begin
            pix_en <= ~pix_en; // half the sys_clk rate
            if (pix_en) begin
                h_cnt <= h_next;
                v_cnt <= v_next;
                // decoded from the next count so they change with the counters
                hsync <= !(h_next >= coord_w'(h_sync_start) &&
                           h_next <  coord_w'(h_sync_end));
                vsync <= !(v_next >= coord_w'(v_sync_start) &&
                           v_next <  coord_w'(v_sync_end));
            end
        end
    end

    assign scan.pix_en  = pix_en;
    assign scan.hcount  = h_cnt;
    assign scan.vcount  = v_cnt;
    assign scan.visible = (h_cnt < coord_w'(h_visible)) && (v_cnt < coord_w'(v_visible));

endmodule

`default_nettype wire

/* logic/sprite_rom.sv */
`timescale 1ns/1ps
`default_nettype none

module sprite_rom #(
    parameter int data_w = 16,
    parameter int addr_w = 9
) (
    input  logic              sys_clk,
    input  logic [addr_w-1:0] addr_a,
    input  logic [addr_w-1:0] addr_b,
    output logic [data_w-1:0] q_a,
    output logic [data_w-1:0] q_b
);
    import sprite_pkg::*;

    logic [data_w-1:0] mem [2**addr_w];

    // one sprite per sprite_dim*sprite_dim block of words
    initial begin
        for (int i = 0; i < 2**addr_w; i++) begin
            mem[i] = data_w'(texel_at(i / (sprite_dim * sprite_dim),
                                      (i / sprite_dim) % sprite_dim,
                                      i % sprite_dim));
        end
    end

    always_ff @(posedge sys_clk) begin
        q_a <= mem[addr_a];
        q_b <= mem[addr_b];
    end

endmodule

`default_nettype wire

/* logic/sprite_renderer.sv */
`timescale 1ns/1ps
`default_nettype none

module sprite_renderer #(
    parameter logic [sprite_pkg::rom_addr_w-1:0] base      = sprite_pkg::player_base,
    parameter bit                                is_player = 1'b1
) (
    input  logic                             sys_clk,
    input  logic                             reset,
    scan_if.sink                             scan,
    sprite_pos_if.sink                       pos,
    output logic [sprite_pkg::rom_addr_w-1:0] rom_addr,
    input  logic [sprite_pkg::texel_w-1:0]    rom_q,
    output logic [23:0]                       rgb,
    output logic                              opaque
);
    import video_pkg::*;
    import sprite_pkg::*;

    logic [coord_w-1:0] px;
    logic [coord_w-1:0] py;
    logic [coord_w-1:0] dx;
    logic [coord_w-1:0] dy;
    logic               in_x;
    logic               in_y;
    logic               in_box;
    logic               in_box_d1; // lines up with rom_addr
    logic               in_box_d2; // lines up with rom_q

    // which half of the position interface belongs to this sprite
    assign px = is_player ? pos.player_x : pos.obstacle_x;
    assign py = is_player ? pos.player_y : pos.obstacle_y;

    assign dx   = scan.hcount - px;
    assign dy   = scan.vcount - py;
    assign in_x = (scan.hcount >= px) && (dx < coord_w'(sprite_dim));
    assign in_y = (scan.vcount >= py) && (dy < coord_w'(sprite_dim));

    // anything outside the visible area is clipped here
    assign in_box = in_x && in_y && scan.visible;

    always_ff @(posedge sys_clk) begin
        rom_addr <= base + rom_addr_w'({dy[sprite_bits-1:0], dx[sprite_bits-1:0]});
    end

    always_ff @(posedge sys_clk or negedge reset) begin
        if (!reset) begin
            in_box_d1 <= 1'b0;
            in_box_d2 <= 1'b0;
        end else begin
            in_box_d1 <= in_box;
            in_box_d2 <= in_box_d1;
        end
    end

    // texel fields: opaque, red, green, blue
    assign rgb = {expand_ch(rom_q[14:10]), expand_ch(rom_q[9:5]), expand_ch(rom_q[4:0])};
    assign opaque = in_box_d2 && rom_q[texel_w-1];

endmodule

`default_nettype wire

/* logic/position_loader.sv */
`timescale 1ns/1ps
`default_nettype none

module position_loader (
    input  logic                        sys_clk,
    input  logic                        reset,
    scan_if.sink                        scan,
    sprite_pos_if.source                pos,
    output logic                        psel,
    output logic                        penable,
    output logic [sprite_pkg::apb_w-1:0] paddr,
    input  logic                        pready,
    input  logic [sprite_pkg::apb_w-1:0] prdata
);
    import video_pkg::*;
    import sprite_pkg::*;

    loader_state_t      state;
    logic [1:0]         idx;           // word being read
    logic [coord_w-1:0] shadow [4];
    logic               vb_start;
    logic               last_word;

    // first of the two cycles at the top of vertical blank
    assign vb_start = (scan.hcount == '0) && (scan.vcount == coord_w'(v_visible)) &&
                      !scan.pix_en;
    assign last_word = (idx == 2'd3);

    assign psel    = (state == setup) || (state == access);
    assign penable = (state == access);
    assign paddr   = pos_base + apb_w'(idx);

    always_ff @(posedge sys_clk or negedge reset) begin
        if (!reset) begin
            state          <= idle;
            idx            <= '0;
            pos.player_x   <= '0;
            pos.player_y   <= '0;
            pos.obstacle_x <= '0;
            pos.obstacle_y <= '0;
        end else begin
            case (state)
                idle: begin
                    if (vb_start) begin
                        state <= setup;
                        idx   <= '0;
                    end
                end
                setup: state <= access;
                access: begin
                    if (pready) begin // otherwise hold, slave is stalling
                        if (last_word) begin
                            state <= commit;
                        end else begin
                            idx   <= idx + 2'd1;
                            state <= setup;
                        end
                    end
                end
                commit: begin
                    // all four at once, never mid-frame
                    pos.player_x   <= shadow[0];
                    pos.player_y   <= shadow[1];
                    pos.obstacle_x <= shadow[2];
                    pos.obstacle_y <= shadow[3];
                    state          <= idle;
                end
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge sys_clk) begin
        if (state == access && pready) begin
            shadow[idx] <= prdata[coord_w-1:0]; // upper bits ignored
        end
    end

endmodule

`default_nettype wire

/* logic/pixel_compositor.sv */
`timescale 1ns/1ps
`default_nettype none

module pixel_compositor (
    input  logic        sys_clk,
    input  logic        reset,
    scan_if.sink        scan,
    input  logic        hsync_in,
    input  logic        vsync_in,
    input  logic [23:0] player_rgb,
    input  logic        player_opaque,
    input  logic [23:0] obstacle_rgb,
    input  logic        obstacle_opaque,
    output logic [7:0]  vga_r,
    output logic [7:0]  vga_g,
    output logic [7:0]  vga_b,
    output logic        hsync,
    output logic        vsync,
    output logic        blank_n,
    output logic        vga_clk
);
    import video_pkg::*;

    // two stages to match renderer reg + rom read
    logic [1:0]  vis_d;
    logic [1:0]  hs_d;
    logic [1:0]  vs_d;
    logic [23:0] pix_rgb;

    always_comb begin
        if (!vis_d[1]) begin
            pix_rgb = 24'h000000;
        end else if (player_opaque) begin
            pix_rgb = player_rgb; // player in front
        end else if (obstacle_opaque) begin
            pix_rgb = obstacle_rgb;
        end else begin
            pix_rgb = bg_rgb;
        end
    end

    always_ff @(posedge sys_clk or negedge reset) begin
        if (!reset) begin
            vis_d   <= '0;
            hs_d    <= '1;
            vs_d    <= '1;
            vga_r   <= '0;
            vga_g   <= '0;
            vga_b   <= '0;
            hsync   <= 1'b1;
            vsync   <= 1'b1;
            blank_n <= 1'b0;
            vga_clk <= 1'b0;
        end else begin
            vis_d   <= {vis_d[0], scan.visible};
            hs_d    <= {hs_d[0], hsync_in};
            vs_d    <= {vs_d[0], vsync_in};
            vga_r   <= pix_rgb[23:16];
            vga_g   <= pix_rgb[15:8];
            vga_b   <= pix_rgb[7:0];
            hsync   <= hs_d[1];
            vsync   <= vs_d[1];
            blank_n <= vis_d[1];
            // high as each new pixel lands, phase set by the pipeline depth
            vga_clk <= scan.pix_en ^ 1'(pipe_depth % 2);
        end
    end

endmodule

`default_nettype wire

/* logic/sprite_display_top.sv */
`timescale 1ns/1ps
`default_nettype none

module sprite_display_top (
    input  logic                        sys_clk,
    input  logic                        reset,
    input  logic                        pready,
    input  logic [sprite_pkg::apb_w-1:0] prdata,
    output logic                        psel,
    output logic                        penable,
    output logic [sprite_pkg::apb_w-1:0] paddr,
    output logic [7:0]                  vga_r,
    output logic [7:0]                  vga_g,
    output logic [7:0]                  vga_b,
    output logic                        hsync,
    output logic                        vsync,
    output logic                        blank_n,
    output logic                        vga_clk
);
    import sprite_pkg::*;

    scan_if       scan ();
    sprite_pos_if pos ();

    logic                  hsync_raw;
    logic                  vsync_raw;
    logic [rom_addr_w-1:0] player_addr;
    logic [rom_addr_w-1:0] obstacle_addr;
    logic [texel_w-1:0]    player_q;
    logic [texel_w-1:0]    obstacle_q;
    logic [23:0]           player_rgb;
    logic [23:0]           obstacle_rgb;
    logic                  player_opaque;
    logic                  obstacle_opaque;

    vga_timing u_timing (
        .sys_clk (sys_clk),
        .reset   (reset),
        .scan    (scan),
        .hsync   (hsync_raw),
        .vsync   (vsync_raw)
    );

    position_loader u_loader (
        .sys_clk (sys_clk),
        .reset   (reset),
        .scan    (scan),
        .pos     (pos),
        .psel    (psel),
        .penable (penable),
        .paddr   (paddr),
        .pready  (pready),
        .prdata  (prdata)
    );

    // port a serves the player, port b the obstacle
    sprite_rom #(
        .data_w (texel_w),
        .addr_w (rom_addr_w)
    ) u_rom (
        .sys_clk (sys_clk),
        .addr_a  (player_addr),
        .addr_b  (obstacle_addr),
        .q_a     (player_q),
        .q_b     (obstacle_q)
    );

    sprite_renderer #(
        .base      (player_base),
        .is_player (1'b1)
    ) u_player (
        .sys_clk  (sys_clk),
        .reset    (reset),
        .scan     (scan),
        .pos      (pos),
        .rom_addr (player_addr),
        .rom_q    (player_q),
        .rgb      (player_rgb),
        .opaque   (player_opaque)
    );

    sprite_renderer #(
        .base      (obstacle_base),
        .is_player (1'b0)
    ) u_obstacle (
        .sys_clk  (sys_clk),
        .reset    (reset),
        .scan     (scan),
        .pos      (pos),
        .rom_addr (obstacle_addr),
        .rom_q    (obstacle_q),
        .rgb      (obstacle_rgb),
        .opaque   (obstacle_opaque)
    );

    pixel_compositor u_comp (
        .sys_clk         (sys_clk),
        .reset           (reset),
        .scan            (scan),
        .hsync_in        (hsync_raw),
        .vsync_in        (vsync_raw),
        .player_rgb      (player_rgb),
        .player_opaque   (player_opaque),
        .obstacle_rgb    (obstacle_rgb),
        .obstacle_opaque (obstacle_opaque),
        .vga_r           (vga_r),
        .vga_g           (vga_g),
        .vga_b           (vga_b),
        .hsync           (hsync),
        .vsync           (vsync),
        .blank_n         (blank_n),
        .vga_clk         (vga_clk)
    );

endmodule

`default_nettype wire

/* tb/sprite_display_props.sv */
`timescale 1ns/1ps
`default_nettype none

module sprite_display_props (
    input logic                        sys_clk,
    input logic                        reset,
    input logic                        psel,
    input logic                        penable,
    input logic [sprite_pkg::apb_w-1:0] paddr,
    input logic                        pready,
    input logic                        visible
);

    // access only ever follows a setup cycle
    penable_needs_psel: assert property (@(posedge sys_clk) disable iff (!reset)
        penable |-> psel && $past(psel))
        else $error("penable without psel or without a setup phase");

    // setup is always followed by access on the same address
    setup_to_access: assert property (@(posedge sys_clk) disable iff (!reset)
        psel && !penable |=> psel && penable && $stable(paddr))
        else $error("setup phase not followed by a matching access phase");

    access_hold: assert property (@(posedge sys_clk) disable iff (!reset)
        psel && penable && !pready |=> psel && penable && $stable(paddr))
        else $error("paddr or control changed during wait states");

    quiet_in_visible: assert property (@(posedge sys_clk) disable iff (!reset)
        visible |-> !psel) else $error("apb access in visible area");

endmodule

bind position_loader sprite_display_props u_props (
    .sys_clk (sys_clk),
    .reset   (reset),
    .psel    (psel),
    .penable (penable),
    .paddr   (paddr),
    .pready  (pready),
    .visible (scan.visible)
);

`default_nettype wire

/* tb/sprite_display_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module sprite_display_tb;
    import video_pkg::*;
    import sprite_pkg::*;

    localparam int frames_to_run = 5;
    localparam int frame_limit   = 2 * h_total * v_total + 1000; // cycles per frame plus slack

    logic             sys_clk;
    logic             reset;
    logic             pready;
    logic [apb_w-1:0] prdata;
    logic             psel;
    logic             penable;
    logic [apb_w-1:0] paddr;
    logic [7:0]       vga_r;
    logic [7:0]       vga_g;
    logic [7:0]       vga_b;
    logic             hsync;
    logic             vsync;
    logic             blank_n;
    logic             vga_clk;

    logic [31:0]      seed;
    logic [apb_w-1:0] pending [4];   // served on the next load
    logic [apb_w-1:0] committed [4]; // shown in the current frame
    int               rd_idx;
    int               wait_left;
    int               loads;
    int               h;
    int               v;
    bit               h_locked;
    bit               v_locked;
    logic             prev_hs;
    logic             prev_vs;
    logic [26:0]      held_out;      // syncs, blank_n and colour of the current pixel
    bit               held_valid;
    int               frame_count;
    bit               timed_out;
    int               reset_errors;
    int               sync_errors;
    int               apb_errors;
    int               pixel_errors;

    sprite_display_top uut (
        .sys_clk (sys_clk),
        .reset   (reset),
        .pready  (pready),
        .prdata  (prdata),
        .psel    (psel),
        .penable (penable),
        .paddr   (paddr),
        .vga_r   (vga_r),
        .vga_g   (vga_g),
        .vga_b   (vga_b),
        .hsync   (hsync),
        .vsync   (vsync),
        .blank_n (blank_n),
        .vga_clk (vga_clk)
    );

    initial begin
        sys_clk = 1'b0;
        forever #2 sys_clk = ~sys_clk;
    end

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed >> 8; // low bits of an lcg repeat quickly
    endfunction

    function automatic logic [7:0] widen5(input logic [4:0] c);
        return {c, c[4:2]};
    endfunction

    // {opaque, rgb} of one sprite texel
    function automatic logic [24:0] sprite_texel(input int sprite, input int row, input int col);
        logic [4:0] r;
        logic [4:0] g;
        logic [4:0] b;
        r = 5'(col * 2);
        g = 5'(row * 2);
        b = (sprite == 0) ? 5'd31 : 5'd0;
        return {((row + col) % 4) != 0, widen5(r), widen5(g), widen5(b)};
    endfunction

    function automatic logic [23:0] expected_pixel(input int x, input int y);
        logic [24:0] pt;
        logic [24:0] ot;
        int          px;
        int          py;
        int          ox;
        int          oy;
        px = int'(committed[0]);
        py = int'(committed[1]);
        ox = int'(committed[2]);
        oy = int'(committed[3]);
        pt = '0;
        ot = '0;
        if (x >= h_visible || y >= v_visible) return 24'h000000;
        if (x >= px && x < px + sprite_dim && y >= py && y < py + sprite_dim)
            pt = sprite_texel(0, y - py, x - px);
        if (x >= ox && x < ox + sprite_dim && y >= oy && y < oy + sprite_dim)
            ot = sprite_texel(1, y - oy, x - ox);
        if (pt[24]) return pt[23:0]; // player in front
        if (ot[24]) return ot[23:0];
        return bg_rgb;
    endfunction

    // odd loads overlap the two boxes
    // load 2 hangs off the bottom right corner
    task automatic refill_positions();
        int px;
        int py;
        int ox;
        int oy;
        ox = int'(lcg_next() % 661);
        oy = int'(lcg_next() % 501);
        px = int'(lcg_next() % 661);
        py = int'(lcg_next() % 501);
        if (loads % 2 == 1) begin
            px = (ox >= 12) ? ox - int'(lcg_next() % 12) : ox + int'(lcg_next() % 12);
            py = (oy >= 12) ? oy - int'(lcg_next() % 12) : oy + int'(lcg_next() % 12);
        end
        if (loads == 2) begin
            px = 632;
            py = 472;
            ox = 628;
            oy = 470;
        end
        pending[0] = 16'(px);
        pending[1] = 16'(py);
        pending[2] = 16'(ox);
        pending[3] = 16'(oy);
    endtask

    // apb memory with random wait states
    always @(posedge sys_clk) begin
        if (!reset) begin
            pready <= 1'b0;
        end else if (psel && !penable) begin
            assert (paddr == pos_base + 16'(rd_idx)) else begin
                apb_errors++;
                $display("[FAIL] %0t: setup paddr %h, expected %h", $time, paddr,
                         pos_base + 16'(rd_idx));
            end
            wait_left = int'(lcg_next() % 4);
            pready <= (wait_left == 0);
            prdata <= pending[rd_idx];
        end else if (psel && penable) begin
            if (pready) begin
                pready <= 1'b0;
                if (rd_idx == 3) begin
                    committed = pending; // dut commits on the next cycle
                    loads++;
                    refill_positions();
                    rd_idx = 0;
                end else begin
                    rd_idx++;
                end
            end else begin
                wait_left--;
                pready <= (wait_left == 0);
            end
        end
    end

    task automatic check_pixel();
        logic [23:0] want;
        bit          vis;
        assert (blank_n || {vga_r, vga_g, vga_b} == 24'h000000) else begin
            pixel_errors++;
            $display("[FAIL] %0t: colour %h while blanked", $time, {vga_r, vga_g, vga_b});
        end
        if (h_locked && v_locked) begin
            vis  = (h < h_visible) && (v < v_visible);
            want = expected_pixel(h, v);
            assert (hsync == !(h >= h_sync_start && h < h_sync_end) &&
                    vsync == !(v >= v_sync_start && v < v_sync_end)) else begin
                sync_errors++;
                $display("[FAIL] %0t: syncs %b%b wrong at h %0d v %0d", $time, hsync, vsync, h, v);
            end
            assert (blank_n == vis && {vga_r, vga_g, vga_b} == want) else begin
                pixel_errors++;
                $display("[FAIL] %0t: pixel h %0d v %0d got %b %h, expected %b %h", $time, h, v,
                         blank_n, {vga_r, vga_g, vga_b}, vis, want);
            end
        end
    endtask

    // reference scan position locked to the first sync edges
    always @(posedge sys_clk) begin
        if (reset && vga_clk) begin
            if (h_locked) begin
                h = (h == h_total - 1) ? 0 : h + 1;
                if (h == 0 && v_locked) begin
                    v = (v == v_total - 1) ? 0 : v + 1;
                    if (v == 0) begin
                        frame_count++;
                        assert (loads == frame_count && rd_idx == 0) else begin
                            apb_errors++;
                            $display("[FAIL] %0t: %0d loads by frame %0d", $time, loads,
                                     frame_count);
                        end
                    end
                end
            end
            if (prev_hs && !hsync) begin
                if (!h_locked) h = h_sync_start;
                assert (h == h_sync_start) else begin
                    sync_errors++;
                    $display("[FAIL] %0t: hsync fell at h %0d", $time, h);
                end
                h_locked = 1'b1;
            end
            if (prev_vs && !vsync && h_locked) begin
                if (!v_locked) v = v_sync_start;
                assert (v == v_sync_start && h == 0) else begin
                    sync_errors++;
                    $display("[FAIL] %0t: vsync fell at h %0d v %0d", $time, h, v);
                end
                v_locked = 1'b1;
            end
            prev_hs = hsync;
            prev_vs = vsync;
            check_pixel();
            held_out   = {hsync, vsync, blank_n, vga_r, vga_g, vga_b};
            held_valid = 1'b1;
        end else if (reset && held_valid) begin
            // second cycle of a pixel repeats the first
            assert ({hsync, vsync, blank_n, vga_r, vga_g, vga_b} == held_out) else begin
                pixel_errors++;
                $display("[FAIL] %0t: outputs %h with vga_clk low, expected %h", $time,
                         {hsync, vsync, blank_n, vga_r, vga_g, vga_b}, held_out);
            end
        end
    end

    task automatic check_reset_values();
        assert (!psel && !penable && !vga_clk && hsync && vsync && !blank_n &&
                {vga_r, vga_g, vga_b} == 24'h000000) else begin
            reset_errors++;
            $display("[FAIL] %0t: outputs not inactive in reset", $time);
        end
        assert (uut.pos.player_x == '0 && uut.pos.player_y == '0 &&
                uut.pos.obstacle_x == '0 && uut.pos.obstacle_y == '0) else begin
            reset_errors++;
            $display("[FAIL] %0t: positions not zero in reset", $time);
        end
    endtask

    task automatic wait_frame(input int target);
        int n;
        n = 0;
        while (frame_count < target && n < frame_limit) begin
            @(posedge sys_clk);
            n++;
        end
        if (frame_count < target) begin
            $display("timeout: frame %0d never started", target);
            timed_out = 1'b1;
        end
    endtask

    initial begin
        reset      = 1'b0;
        pready     = 1'b0;
        prdata     = '0;
        seed       = 32'hf2c8_316f;
        rd_idx     = 0;
        loads      = 0;
        h          = 0;
        v          = 0;
        h_locked   = 1'b0;
        v_locked   = 1'b0;
        prev_hs    = 1'b1;
        prev_vs    = 1'b1;
        held_out   = '0;
        held_valid = 1'b0;
        committed  = '{default: '0};
        refill_positions();
        @(posedge sys_clk);
        @(posedge sys_clk);
        check_reset_values();
        reset <= 1'b1;
        for (int f = 1; f <= frames_to_run && !timed_out; f++) begin
            wait_frame(f);
        end
        $display("errors: reset %0d, sync %0d, apb %0d, pixel %0d, loads seen %0d",
                 reset_errors, sync_errors, apb_errors, pixel_errors, loads);
        if (timed_out || reset_errors + sync_errors + apb_errors + pixel_errors != 0) begin
            $display("Done: errors found");
        end else begin
            $display("Done: no errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
logic/video_pkg.sv
logic/sprite_pkg.sv
logic/display_ifs.sv
logic/vga_timing.sv
logic/sprite_rom.sv
logic/sprite_renderer.sv
logic/position_loader.sv
logic/pixel_compositor.sv
logic/sprite_display_top.sv
tb/sprite_display_props.sv
tb/sprite_display_tb.sv

/* run_sim.sh */
#!/bin/sh
# build with verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert --top-module sprite_display_tb -f flist.f -o sprite_sim \
    && out="$(./obj_dir/sprite_sim 2>&1)" \
    ; echo "$out" \
    && echo "$out" | grep -qxF "Done: no errors" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
